/* list.f */
+incdir+verif
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/decoder.sv
hdl/processor.sv
hdl/busArbiter.sv
hdl/wordMemory.sv
hdl/cpuSystem.sv
verif/tb_cpuSystem.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  - hdl/cpuPkg.sv
  - hdl/registerFile.sv
  - hdl/alu.sv
  - hdl/decoder.sv
  - hdl/processor.sv
  - hdl/busArbiter.sv
  - hdl/wordMemory.sv
  - hdl/cpuSystem.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_cpuSystem.sv

/* verif/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

word_t modelRegs [16];
word_t modelMem [2**memAddrBits];
word_t modelPc;
logic modelC;
logic modelZ;

task automatic resetModel();
	foreach (modelRegs[i]) begin
		modelRegs[i] = '0;
	end
	modelPc = '0;
	modelC = 1'b0;
	modelZ = 1'b0;
endtask

// Runs the instruction at modelPc and reports any store it makes
task automatic stepModel(output logic isStore, output busReq_s store);
	instr_u ins;
	word_t a;
	word_t b;
	word_t r;
	word_t imm;
	logic c;
	ins = modelMem[modelPc[memAddrBits-1:0]];
	a = modelRegs[ins.regForm.dst];
	b = modelRegs[ins.regForm.src];
	imm = {8'h00, ins.immForm.imm};
	r = '0;
	c = 1'b0;
	isStore = 1'b0;
	store = '0;
	modelPc = modelPc + 16'd1;
	case (ins.regForm.opcode)
		opAdd: {c, r} = {1'b0, a} + {1'b0, b};
		// Borrow whenever src exceeds dst
		opSub: {c, r} = {a < b, a - b};
		opAnd: r = a & b;
		opOr: r = a | b;
		opXor: r = a ^ b;
		opShl: {c, r} = {a, 1'b0};
		opShr: {r, c} = {1'b0, a};
		opMov: modelRegs[ins.regForm.dst] = b;
		opLdi: modelRegs[ins.immForm.dst] = imm;
		opLd: modelRegs[ins.regForm.dst] = modelMem[b[memAddrBits-1:0]];
		opSt: begin
			isStore = 1'b1;
			store = '{addr: a, wdata: b, we: 1'b1};
			modelMem[a[memAddrBits-1:0]] = b;
		end
		opJmp: modelPc = imm;
		opJz: modelPc = modelZ ? imm : modelPc;
		opJc: modelPc = modelC ? imm : modelPc;
		opJr: modelPc = b;
		default: r = '0;
	endcase
	// Only the ALU group writes flags
	if (ins.regForm.opcode <= opShr) begin
		modelRegs[ins.regForm.dst] = r;
		modelC = c;
		modelZ = (r == '0);
	end
endtask

`endif

/* verif/tb_cpuSystem.sv */
module tb_cpuSystem
	import cpuPkg::*;
();

	localparam int memAddrBits = 8;
	localparam int memWords = 2 ** memAddrBits;
	localparam int haltAddr = 119;
	localparam int dataBase = 128;
	// 480 model steps at up to 3 cycles each with a margin of two
	localparam int stepLimit = 4 * (haltAddr + 1);
	localparam int cycleLimit = 2 * 3 * stepLimit;

	logic clk;
	logic rst;
	logic hostEn;
	busReq_s hostReq;
	word_t hostRData;
	word_t busAddr;
	word_t busWData;
	logic busWe;
	logic busGrant;

	integer seed = 32'he5f2_3590;
	int mismatches = 0;
	int failures = 0;
	int fetches = 0;
	int stores = 0;
	int stallLeft = 0;
	logic execPhase = 1'b0;
	logic halted = 1'b0;
	logic expStore;
	busReq_s expReq;
	word_t fetchPc;

	`include "cpuModel.svh"

	cpuSystem #(.memAddrBits(memAddrBits)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int unsigned randBelow(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic reportFailure(input string what);
		failures++;
		$display("%s", what);
	endtask

	task automatic matchFetchAddr(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compareStore(input string name, input busReq_s exp, input busReq_s act);
		if (act !== exp) begin
			mismatches++;
			$display("mismatch %s: expected addr %h data %h we %b, actual addr %h data %h we %b",
				name, exp.addr, exp.wdata, exp.we, act.addr, act.wdata, act.we);
		end
	endtask

	task automatic checkMemWord(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Program in words 0 to haltAddr and random data elsewhere
	task automatic buildImage();
		opcode_e op;
		regIdx_t d;
		regIdx_t lastDst;
		int pos;
		int target;
		foreach (modelMem[a]) begin
			modelMem[a] = word_t'($random(seed));
		end
		for (int r = 0; r < 16; r++) begin
			modelMem[r] = {opLdi, regIdx_t'(r), 8'(randBelow(256))};
		end
		pos = 16;
		lastDst = '0;
		while (pos < haltAddr) begin
			op = opcode_e'(randBelow(16));
			d = regIdx_t'(randBelow(16));
			// Forward targets keep the halt loop reachable
			target = pos + 1 + int'(randBelow(4)) + int'(op == opJr);
			if (target > haltAddr) begin
				target = haltAddr;
			end
			if (op inside {opLd, opSt, opJr} && pos + 1 >= haltAddr) begin
				op = opNop;
			end
			if (op == opJr) begin
				// r13 carries the jump target
				modelMem[pos] = {opLdi, 4'd13, 8'(target)};
				modelMem[pos + 1] = {opJr, 4'h0, 4'd13, 4'h0};
				pos += 2;
			end else if (op inside {opLd, opSt}) begin
				// r14 points into the data region
				modelMem[pos] = {opLdi, 4'd14, 8'(dataBase + randBelow(128))};
				if (op == opLd) begin
					modelMem[pos + 1] = {opLd, d, 4'd14, 4'h0};
				end else begin
					// Latest ALU result goes out to memory
					modelMem[pos + 1] = {opSt, 4'd14, lastDst, 4'h0};
				end
				pos += 2;
			end else if (op inside {opLdi, opJmp, opJz, opJc}) begin
				modelMem[pos] = {op, d, 8'(op == opLdi ? randBelow(256) : target)};
				pos++;
			end else begin
				modelMem[pos] = {op, d, 4'(randBelow(16)), 4'(randBelow(16))};
				if (op <= opShr) begin
					lastDst = d;
				end
				pos++;
			end
		end
		modelMem[haltAddr] = {opJmp, 4'h0, 8'(haltAddr)};
	endtask

	// Host reads steal the bus for 1 to 3 cycles now and then
	task automatic driveHostStall();
		if (stallLeft == 0 && randBelow(8) == 0) begin
			stallLeft = 1 + randBelow(3);
		end
		hostEn = (stallLeft > 0);
		stallLeft = (stallLeft > 0) ? stallLeft - 1 : 0;
		hostReq = '{addr: word_t'(randBelow(memWords)), wdata: '0, we: 1'b0};
	endtask

	// Granted cycles alternate fetch and execute
	task automatic followTrace();
		busReq_s seen;
		seen = '{addr: busAddr, wdata: busWData, we: busWe};
		if (hostEn) begin
			if (busGrant !== 1'b0) reportFailure("processor granted while the host holds the bus");
		end else if (busGrant !== 1'b1) begin
			reportFailure("processor not granted although the host is idle");
		end else if (!execPhase) begin
			matchFetchAddr($sformatf("fetch %0d", fetches), modelPc, busAddr);
			if (busWe !== 1'b0) reportFailure("write strobe during an instruction fetch");
			fetchPc = modelPc;
			stepModel(expStore, expReq);
			fetches++;
			execPhase = 1'b1;
		end else begin
			if (expStore) begin
				compareStore($sformatf("store at pc %0d", fetchPc), expReq, seen);
				stores++;
			end else if (busWe !== 1'b0) begin
				reportFailure($sformatf("bus write from a non-store instruction at pc %0d", fetchPc));
			end
			execPhase = 1'b0;
			halted = (fetchPc == word_t'(haltAddr));
		end
	endtask

	initial begin
		rst = 1'b1;
		hostEn = 1'b0;
		hostReq = '0;
		resetModel();
		buildImage();
		repeat (3) @(posedge clk);
		if (busWe !== 1'b0 || busAddr !== 16'h0000) reportFailure("bus not idle at address 0 in reset");
		#10;
		rst = 1'b0;
		foreach (modelMem[a]) begin
			hostEn = 1'b1;
			hostReq = '{addr: word_t'(a), wdata: modelMem[a], we: 1'b1};
			@(posedge clk);
			#10;
		end
		for (int cycle = 0; cycle < cycleLimit && !halted; cycle++) begin
			driveHostStall();
			#40;
			followTrace();
			@(posedge clk);
			#10;
		end
		if (!halted) begin
			reportFailure($sformatf("timeout: no halt loop reached within %0d cycles", cycleLimit));
		end else begin
			// Processor spins in its halt loop while the host reads back
			for (int a = dataBase; a < memWords; a++) begin
				hostEn = 1'b1;
				hostReq = '{addr: word_t'(a), wdata: '0, we: 1'b0};
				#40;
				checkMemWord($sformatf("data word %0d", a), modelMem[a], hostRData);
				@(posedge clk);
				#10;
			end
		end
		hostEn = 1'b0;
		$display("errors %0d, mismatches %0d, other failures %0d, fetches %0d, stores %0d",
			mismatches + failures, mismatches, failures, fetches, stores);
		if (mismatches + failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* hdl/cpuSystem.sv */
module cpuSystem
	import cpuPkg::*;
#(
	parameter int memAddrBits = 8
) (
	input logic clk,
	input logic rst,
	input logic hostEn,
	input busReq_s hostReq,
	output word_t hostRData,
	output word_t busAddr,
	output word_t busWData,
	output logic busWe,
	output logic busGrant
);

	busReq_s cpuReq;
	busReq_s memReq;
	word_t rdata;
	logic grant;

	processor cpu (
		.clk(clk),
		.rst(rst),
		.cpuReq(cpuReq),
		.rdata(rdata),
		.grant(grant)
	);

	busArbiter #(
		.memAddrBits(memAddrBits)
	) arbiter (
		.hostEn(hostEn),
		.hostReq(hostReq),
		.cpuReq(cpuReq),
		.memReq(memReq),
		.grant(grant)
	);

	wordMemory #(
		.memAddrBits(memAddrBits)
	) memory (
		.clk(clk),
		.req(memReq),
		.rdata(rdata)
	);

	// Processor side of the bus, for tracing
	assign busAddr = cpuReq.addr;
	assign busWData = cpuReq.wdata;
	assign busWe = cpuReq.we;
	assign busGrant = grant;
	assign hostRData = rdata;

endmodule

/* hdl/wordMemory.sv */
module wordMemory
	import cpuPkg::*;
#(
	parameter int memAddrBits = 8
) (
	input logic clk,
	input busReq_s req,
	output word_t rdata
);

	word_t mem [2**memAddrBits];
	logic [memAddrBits-1:0] index;

	assign index = req.addr[memAddrBits-1:0];
	assign rdata = mem[index];

	always_ff @(posedge clk) begin
		if (req.we) begin
			mem[index] <= req.wdata;
		end
	end

endmodule

/* hdl/busArbiter.sv */
module busArbiter
	import cpuPkg::*;
#(
	parameter int memAddrBits = 8
) (
	input logic hostEn,
	input busReq_s hostReq,
	input busReq_s cpuReq,
	output busReq_s memReq,
	output logic grant
);

	busReq_s winner;

	// Host always wins
	assign winner = hostEn ? hostReq : cpuReq;
	assign grant = ~hostEn;

	always_comb begin
		memReq = winner;
		memReq.addr = '0;
		memReq.addr[memAddrBits-1:0] = winner.addr[memAddrBits-1:0];
	end

endmodule

/* hdl/processor.sv */
module processor
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	output busReq_s cpuReq,
	input word_t rdata,
	input logic grant
);

	typedef enum logic {
		stFetch = 1'b0,
		stExec  = 1'b1
	} state_e;

	state_e state;
	word_t pc;
	word_t nextPc;
	instr_u ir;
	ctrl_s ctrl;

	word_t dstData;
	word_t srcData;
	word_t wbData;
	word_t aluResult;
	logic cFlag;
	logic zFlag;
	logic commit;

	// Execute step completes only when the bus is ours
	assign commit = (state == stExec) && grant;

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.we(ctrl.regWe && commit),
		.dst(ctrl.dst),
		.src(ctrl.src),
		.wdata(wbData),
		.dstData(dstData),
		.srcData(srcData)
	);

	alu aluUnit (
		.clk(clk),
		.rst(rst),
		.op(ctrl.op),
		.a(dstData),
		.b(srcData),
		.flagWe(ctrl.flagWe && commit),
		.result(aluResult),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	decoder decode (
		.instr(ir),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.ctrl(ctrl)
	);

	always_comb begin
		case (ctrl.wbSel)
			wbImm: wbData = ctrl.imm;
			wbMem: wbData = rdata;
			wbSrc: wbData = srcData;
			default: wbData = aluResult;
		endcase

		case (ctrl.pcSel)
			pcImm: nextPc = ctrl.imm;
			pcReg: nextPc = srcData;
			default: nextPc = pc + 16'd1;
		endcase
	end

	// Bus request
	always_comb begin
		cpuReq.addr = pc;
		cpuReq.wdata = srcData;
		cpuReq.we = 1'b0;
		if (state == stExec) begin
			if (ctrl.memRd) begin
				cpuReq.addr = srcData;
			end else if (ctrl.memWe) begin
				cpuReq.addr = dstData;
				cpuReq.we = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= stFetch;
			pc <= '0;
			ir.regForm <= '{opcode: opNop, dst: '0, src: '0, spare: '0};
		end else if (grant) begin
			case (state)
				stFetch: begin
					ir <= rdata;
					state <= stExec;
				end
				stExec: begin
					pc <= nextPc;
					state <= stFetch;
				end
				default: state <= stFetch;
			endcase
		end
	end

endmodule

/* hdl/decoder.sv */
module decoder
	import cpuPkg::*;
(
	input instr_u instr,
	input logic cFlag,
	input logic zFlag,
	output ctrl_s ctrl
);

	always_comb begin
		ctrl.op = instr.regForm.opcode;
		ctrl.dst = instr.regForm.dst;
		ctrl.src = instr.regForm.src;
		ctrl.imm = {8'h00, instr.immForm.imm};
		ctrl.regWe = 1'b0;
		ctrl.flagWe = 1'b0;
		ctrl.wbSel = wbAlu;
		ctrl.pcSel = pcIncr;
		ctrl.memWe = 1'b0;
		ctrl.memRd = 1'b0;

		case (instr.regForm.opcode)
			opAdd, opSub, opAnd, opOr, opXor, opShl, opShr: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			opMov: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = wbSrc;
			end
			opLdi: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = wbImm;
			end
			opLd: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = wbMem;
				ctrl.memRd = 1'b1;
			end
			// Address from dst, data from src
			opSt: ctrl.memWe = 1'b1;
			opJmp: ctrl.pcSel = pcImm;
			opJz: begin
				if (zFlag) begin
					ctrl.pcSel = pcImm;
				end
			end
			opJc: begin
				if (cFlag) begin
					ctrl.pcSel = pcImm;
				end
			end
			opJr: ctrl.pcSel = pcReg;
			default: ctrl.pcSel = pcIncr;
		endcase
	end

endmodule

/* hdl/alu.sv */
module alu
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input opcode_e op,
	input word_t a,
	input word_t b,
	input logic flagWe,
	output word_t result,
	output logic cFlag,
	output logic zFlag
);

	logic carry;
	logic [16:0] wide;

	always_comb begin
		wide = '0;
		carry = 1'b0;
		result = '0;
		case (op)
			opAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				result = wide[15:0];
				carry = wide[16];
			end
			opSub: begin
				// Bit 16 of the extended difference is the borrow
				wide = {1'b0, a} - {1'b0, b};
				result = wide[15:0];
				carry = wide[16];
			end
			opAnd: result = a & b;
			opOr: result = a | b;
			opXor: result = a ^ b;
			opShl: begin
				result = {a[14:0], 1'b0};
				carry = a[15];
			end
			opShr: begin
				result = {1'b0, a[15:1]};
				carry = a[0];
			end
			default: result = '0;
		endcase
	end

	// Flags held for later conditional jumps
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= carry;
			zFlag <= (result == '0);
		end
	end

endmodule

/* hdl/registerFile.sv */
module registerFile
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input logic we,
	input regIdx_t dst,
	input regIdx_t src,
	input word_t wdata,
	output word_t dstData,
	output word_t srcData
);

	word_t regs [16];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[dst] <= wdata;
		end
	end

	// Both read ports are combinational
	assign dstData = regs[dst];
	assign srcData = regs[src];

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] regIdx_t;

	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opAnd = 4'h2,
		opOr  = 4'h3,
		opXor = 4'h4,
		opShl = 4'h5,
		opShr = 4'h6,
		opMov = 4'h7,
		opLdi = 4'h8,
		opLd  = 4'h9,
		opSt  = 4'hA,
		opJmp = 4'hB,
		opJz  = 4'hC,
		opJc  = 4'hD,
		opJr  = 4'hE,
		opNop = 4'hF
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		regIdx_t dst;
		regIdx_t src;
		logic [3:0] spare;
	} regForm_s;

	typedef struct packed {
		opcode_e opcode;
		regIdx_t dst;
		logic [7:0] imm;
	} immForm_s;

	// Same instruction word, two field layouts
	typedef union packed {
		regForm_s regForm;
		immForm_s immForm;
	} instr_u;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic we;
	} busReq_s;

	typedef enum logic [1:0] {
		wbAlu = 2'd0,
		wbImm = 2'd1,
		wbMem = 2'd2,
		wbSrc = 2'd3
	} wbSel_e;

	typedef enum logic [1:0] {
		pcIncr = 2'd0,
		pcImm  = 2'd1,
		pcReg  = 2'd2
	} pcSel_e;

	typedef struct packed {
		opcode_e op;
		regIdx_t dst;
		regIdx_t src;
		logic regWe;
		logic flagWe;
		wbSel_e wbSel;
		pcSel_e pcSel;
		logic memWe;
		logic memRd;
		word_t imm;
	} ctrl_s;

endpackage
